// ==== all.f ====
+incdir+test
common/uart_pkg.sv
logic/uart_tx_framer.sv
logic/uart_tx_shifter.sv
uart_rx/uart_rx_deframer.sv
uart_rx/uart_rx_checker.sv
logic/uart.sv
test/tb_uart.sv

// ==== Bender.yml ====
package:
  name: uart_cmd_port

sources:
  # package first, then the blocks, then the top level.
  - files:
      - common/uart_pkg.sv
      - logic/uart_tx_framer.sv
      - logic/uart_tx_shifter.sv
      - uart_rx/uart_rx_deframer.sv
      - uart_rx/uart_rx_checker.sv
      - logic/uart.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tb_uart.sv

// ==== test/tb_uart_tasks.svh ====
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// a parity bit of 1 when the byte has an even count of ones.
function automatic logic ref_parity(input byte_t data);
   int ones;
   ones = 0;
   for (int b = 0; b < 8; b++) begin
      ones += data[b];
   end
   return (ones % 2 == 0);
endfunction

// builds a frame in line order with the start bit first, then data LSB first, parity and stop.
function automatic frame_t ref_frame(input byte_t data, input logic flip_par,
                                     input logic bad_stop);
   frame_t f;
   f[0] = 1'b0;
   for (int b = 0; b < 8; b++) begin
      f[b + 1] = data[b];
   end
   f[9]  = ref_parity(data) ^ flip_par;
   f[10] = ~bad_stop;
   return f;
endfunction

function automatic word_t ref_word(input cmd_t cmd);
   return {ref_frame(cmd[15:8], 1'b0, 1'b0), ref_frame(cmd[7:0], 1'b0, 1'b0)};
endfunction

task automatic compare_byte(input string name, input byte_t exp, input byte_t act);
   checks++;
   if (exp !== act) begin
      errors++;
      $display("ERR %s: expected %02h, actual %02h", name, exp, act);
   end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
   checks++;
   if (exp !== act) begin
      errors++;
      $display("ERR %s: expected %b, actual %b", name, exp, act);
   end
endtask

task automatic compare_count(input string name, input int exp, input int act);
   checks++;
   if (exp != act) begin
      errors++;
      $display("ERR %s: expected %0d, actual %0d", name, exp, act);
   end
endtask

task automatic report_timeout(input string name, input string what);
   errors++;
   $display("%s: gave up waiting for %s after %0d cycles", name, what, wait_limit);
endtask

task automatic wait_cmd_rdy(input string name);
   int t;
   t = 0;
   while (!cmd_rdy && t < wait_limit) begin
      @(negedge clk);
      t++;
   end
   if (!cmd_rdy) begin
      report_timeout(name, "cmd_rdy to rise");
   end
endtask

task automatic wait_read_bytes(input string name, input int n);
   int t;
   t = 0;
   while (rdy_bytes.size() < n && t < wait_limit) begin
      @(negedge clk);
      t++;
   end
   if (rdy_bytes.size() < n) begin
      report_timeout(name, "a read_rdy pulse");
   end
endtask

task automatic wait_err_pulses(input string name, input int n);
   int t;
   t = 0;
   while (err_pulses < n && t < wait_limit) begin
      @(negedge clk);
      t++;
   end
   if (err_pulses < n) begin
      report_timeout(name, "a frame_err pulse");
   end
endtask

// returns on the falling edge right after the accepting edge, cmd_vld still high.
task automatic start_cmd(input string name, input cmd_t cmd);
   cmd_in  = cmd;
   cmd_vld = 1'b1;
   wait_cmd_rdy(name);
   @(posedge clk);
   @(negedge clk);
endtask

task automatic expect_tx_word(input string name, input cmd_t cmd);
   word_t exp;
   exp = ref_word(cmd);
   compare_bit({name, " cmd_rdy after accept"}, 1'b0, cmd_rdy);
   for (int i = 0; i < 22; i++) begin
      @(negedge clk);
      compare_bit($sformatf("%s tx bit %0d", name, i), exp[i], tx);
   end
   compare_bit({name, " cmd_rdy on last bit"}, 1'b0, cmd_rdy);
   @(negedge clk);
   compare_bit({name, " cmd_rdy after done"}, 1'b1, cmd_rdy);
   compare_bit({name, " tx idle"}, 1'b1, tx);
endtask

task automatic drive_frame(input byte_t data, input logic flip_par, input logic bad_stop);
   frame_t f;
   f = ref_frame(data, flip_par, bad_stop);
   for (int j = 0; j < 11; j++) begin
      rx_drv = f[j];
      @(negedge clk);
   end
   rx_drv = 1'b1;
endtask

task automatic finish_test(input string name, input int e0);
   tests++;
   if (errors == e0) begin
      $display("%-16s passed", name);
   end else begin
      failed_tests++;
      $display("%-16s failed with %0d errors", name, errors - e0);
   end
endtask

`endif

// ==== test/tb_uart.sv ====
`timescale 1ns/10ps

module tb_uart;

   import uart_pkg::*;

   localparam int reset_cycles = 4;
   localparam int wait_limit   = 100;

   logic  clk;
   logic  rst_n;
   cmd_t  cmd_in;
   logic  cmd_vld;
   logic  cmd_rdy;
   logic  tx;
   logic  rx;
   logic  rx_drv;
   logic  rx_loop;
   logic  loop_en;
   byte_t read_data;
   logic  read_rdy;
   logic  frame_err;

   int    cycle;
   byte_t rdy_bytes[$];
   int    rdy_cycles[$];
   int    err_pulses;
   int    checks;
   int    errors;
   int    tests;
   int    failed_tests;

   assign rx = loop_en ? rx_loop : rx_drv;

   uart DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .tx        (tx),
      .rx        (rx),
      .read_data (read_data),
      .read_rdy  (read_rdy),
      .frame_err (frame_err)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(negedge clk) begin
      rx_loop <= tx;   // tx is copied back onto the receive line.
   end

   // the monitor reads the values the DUT set on the previous edge.
   always @(posedge clk) begin
      if (read_rdy) begin
         rdy_bytes.push_back(read_data);
         rdy_cycles.push_back(cycle);
      end
      if (frame_err) begin
         err_pulses++;
      end
      cycle++;
   end

   `include "tb_uart_tasks.svh"

   task automatic idle_after_reset();
      int e0;
      e0 = errors;
      compare_bit("reset cmd_rdy", 1'b1, cmd_rdy);
      compare_bit("reset tx", 1'b1, tx);
      compare_byte("reset read_data", 8'h00, read_data);
      repeat (20) begin
         @(negedge clk);
         compare_bit("idle read_rdy", 1'b0, read_rdy);
         compare_bit("idle frame_err", 1'b0, frame_err);
      end
      finish_test("idle_after_reset", e0);
   endtask

   task automatic tx_framing();
      int   e0;
      cmd_t cmd;
      e0 = errors;
      for (int n = 0; n < 3; n++) begin
         cmd = cmd_t'($urandom);
         start_cmd("tx_framing", cmd);
         cmd_vld = 1'b0;
         expect_tx_word("tx_framing", cmd);
      end
      finish_test("tx_framing", e0);
   endtask

   task automatic vld_held_high();
      int   e0;
      cmd_t first;
      cmd_t second;
      e0     = errors;
      first  = cmd_t'($urandom);
      second = cmd_t'($urandom);
      start_cmd("vld_held", first);
      cmd_in = second;   // must not reach tx before cmd_rdy comes back.
      expect_tx_word("vld_held first", first);
      start_cmd("vld_held", second);
      cmd_vld = 1'b0;
      expect_tx_word("vld_held second", second);
      repeat (30) begin
         @(negedge clk);
         compare_bit("vld_held idle tx", 1'b1, tx);
         compare_bit("vld_held idle cmd_rdy", 1'b1, cmd_rdy);
      end
      finish_test("vld_held_high", e0);
   endtask

   task automatic loopback();
      int   e0;
      int   base_b;
      int   base_e;
      cmd_t cmd;
      e0      = errors;
      loop_en = 1'b1;
      for (int n = 0; n < 4; n++) begin
         cmd    = cmd_t'($urandom);
         base_b = rdy_bytes.size();
         base_e = err_pulses;
         start_cmd("loopback", cmd);
         cmd_vld = 1'b0;
         wait_cmd_rdy("loopback");
         wait_read_bytes("loopback", base_b + 2);
         repeat (5) @(negedge clk);   // room for a stray pulse to show up.
         if (rdy_bytes.size() >= base_b + 2) begin
            compare_byte("loopback low byte", cmd[7:0], rdy_bytes[base_b]);
            compare_byte("loopback high byte", cmd[15:8], rdy_bytes[base_b + 1]);
         end
         compare_count("loopback read_rdy pulses", base_b + 2, rdy_bytes.size());
         compare_count("loopback frame_err pulses", base_e, err_pulses);
      end
      loop_en = 1'b0;
      finish_test("loopback", e0);
   endtask

   task automatic bad_frame(input string name, input byte_t keep, input byte_t data,
                            input logic flip_par, input logic bad_stop);
      int base_b;
      int base_e;
      base_b = rdy_bytes.size();
      base_e = err_pulses;
      drive_frame(data, flip_par, bad_stop);
      wait_err_pulses(name, base_e + 1);
      repeat (5) @(negedge clk);
      compare_count({name, " frame_err pulses"}, base_e + 1, err_pulses);
      compare_count({name, " read_rdy pulses"}, base_b, rdy_bytes.size());
      compare_byte({name, " read_data"}, keep, read_data);
   endtask

   task automatic error_frames();
      int    e0;
      int    base_b;
      byte_t good;
      e0     = errors;
      good   = byte_t'($urandom);
      base_b = rdy_bytes.size();
      drive_frame(good, 1'b0, 1'b0);
      wait_read_bytes("error_frames", base_b + 1);
      compare_byte("error_frames good byte", good, read_data);
      bad_frame("error_frames parity", good, ~good, 1'b1, 1'b0);
      bad_frame("error_frames stop", good, ~good, 1'b0, 1'b1);
      finish_test("error_frames", e0);
   endtask

   task automatic back_to_back_frames();
      int    e0;
      int    base;
      byte_t b0;
      byte_t b1;
      e0   = errors;
      b0   = byte_t'($urandom);
      b1   = byte_t'($urandom);
      base = rdy_bytes.size();
      drive_frame(b0, 1'b0, 1'b0);
      drive_frame(b1, 1'b0, 1'b0);   // no idle bit in between.
      wait_read_bytes("back_to_back", base + 2);
      if (rdy_bytes.size() >= base + 2) begin
         compare_byte("back_to_back first", b0, rdy_bytes[base]);
         compare_byte("back_to_back second", b1, rdy_bytes[base + 1]);
         compare_count("back_to_back pulse gap", 11,
                       rdy_cycles[base + 1] - rdy_cycles[base]);
      end
      finish_test("back_to_back", e0);
   endtask

   initial begin
      void'($urandom(30302));
      rst_n        = 1'b0;
      cmd_in       = '0;
      cmd_vld      = 1'b0;
      rx_drv       = 1'b1;
      loop_en      = 1'b0;
      cycle        = 0;
      err_pulses   = 0;
      checks       = 0;
      errors       = 0;
      tests        = 0;
      failed_tests = 0;
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
      idle_after_reset();
      tx_framing();
      vld_held_high();
      loopback();
      error_frames();
      back_to_back_frames();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, failed_tests, checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== logic/uart.sv ====
`timescale 1ns/10ps

module uart (
   input  logic            clk,
   input  logic            rst_n,
   input  uart_pkg::cmd_t  cmd_in,
   input  logic            cmd_vld,
   output logic            cmd_rdy,
   output logic            tx,
   input  logic            rx,
   output uart_pkg::byte_t read_data,
   output logic            read_rdy,
   output logic            frame_err
);

   import uart_pkg::*;

   word_t  word;
   logic   load;
   logic   done;
   frame_t frame;
   logic   frame_vld;

   uart_tx_framer u_tx_framer (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .done    (done),
      .cmd_rdy (cmd_rdy),
      .load    (load),
      .word    (word)
   );

   uart_tx_shifter u_tx_shifter (
      .clk   (clk),
      .rst_n (rst_n),
      .load  (load),
      .word  (word),
      .tx    (tx),
      .done  (done)
   );

   uart_rx_deframer u_rx_deframer (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx        (rx),
      .frame     (frame),
      .frame_vld (frame_vld)
   );

   uart_rx_checker u_rx_checker (
      .clk       (clk),
      .rst_n     (rst_n),
      .frame_vld (frame_vld),
      .frame     (frame),
      .read_data (read_data),
      .read_rdy  (read_rdy),
      .frame_err (frame_err)
   );

endmodule

// ==== uart_rx/uart_rx_checker.sv ====
`timescale 1ns/10ps

module uart_rx_checker (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             frame_vld,
   input  uart_pkg::frame_t frame,
   output uart_pkg::byte_t  read_data,
   output logic             read_rdy,
   output logic             frame_err
);

   import uart_pkg::*;

   logic par_ok;
   logic stop_ok;
   logic good;

   // data and parity bits sit next to each other, so one reduction covers both.
   assign par_ok  = ^frame[par_pos:data_lsb];
   assign stop_ok = frame[stop_pos];
   assign good    = par_ok && stop_ok;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_data <= '0;
         read_rdy  <= 1'b0;
         frame_err <= 1'b0;
      end else begin
         read_rdy  <= frame_vld && good;
         frame_err <= frame_vld && !good;
         if (frame_vld && good) begin
            read_data <= frame[data_msb:data_lsb];   // a bad frame keeps the old byte.
         end
      end
   end

endmodule

// ==== uart_rx/uart_rx_deframer.sv ====
`timescale 1ns/10ps

module uart_rx_deframer (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             rx,
   output uart_pkg::frame_t frame,
   output logic             frame_vld
);

   import uart_pkg::*;

   logic                   rx_meta;
   logic                   rx_sync;
   frame_t                 shreg;
   logic [frame_cnt_w-1:0] bit_cnt;   // zero while idle.
   logic                   idle;
   logic                   start_det;
   logic                   capture;
   logic                   last_bit;

   // two flops before any logic looks at the line.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   assign idle      = (bit_cnt == '0);
   assign start_det = idle && !rx_sync;
   assign capture   = start_det || !idle;
   assign last_bit  = (bit_cnt == frame_cnt_w'(stop_pos));

   // bit_cnt names the frame bit taken in this cycle once a start is seen.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_cnt   <= '0;
         frame_vld <= 1'b0;
      end else begin
         frame_vld <= last_bit;
         if (start_det) begin
            bit_cnt <= frame_cnt_w'(data_lsb);
         end else if (last_bit) begin
            bit_cnt <= '0;   // idle again, so a start bit on the next cycle is caught.
         end else if (!idle) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   // bits enter at the top and walk down, so the start bit ends at bit 0.
   always_ff @(posedge clk) begin
      if (capture) begin
         shreg <= {rx_sync, shreg[frame_w-1:1]};
      end
   end

   assign frame = shreg;

endmodule

// ==== logic/uart_tx_shifter.sv ====
`timescale 1ns/10ps

module uart_tx_shifter (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            load,
   input  uart_pkg::word_t word,
   output logic            tx,
   output logic            done
);

   import uart_pkg::*;

   word_t                 sreg;
   logic [word_cnt_w-1:0] bit_cnt;   // index of the bit now on tx.
   logic                  busy;
   logic                  last_bit;
   logic                  next_last;

   assign last_bit  = (bit_cnt == word_cnt_w'(word_w - 1));
   assign next_last = (bit_cnt == word_cnt_w'(word_w - 2));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         bit_cnt <= '0;
         tx      <= 1'b1;
         done    <= 1'b0;
      end else begin
         // done lines up with the last bit, so cmd_rdy rises as tx goes idle.
         done <= busy && !load && next_last;
         if (load) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
            tx      <= word[0];
         end else if (busy) begin
            if (last_bit) begin
               busy <= 1'b0;
               tx   <= 1'b1;   // back to the idle level.
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
               tx      <= sreg[0];
            end
         end
      end
   end

   // holds the bits still to go, next one at bit 0.
   always_ff @(posedge clk) begin
      if (load) begin
         sreg <= word >> 1;
      end else if (busy) begin
         sreg <= sreg >> 1;
      end
   end

endmodule

// ==== logic/uart_tx_framer.sv ====
`timescale 1ns/10ps

module uart_tx_framer (
   input  logic            clk,
   input  logic            rst_n,
   input  uart_pkg::cmd_t  cmd_in,
   input  logic            cmd_vld,
   input  logic            done,
   output logic            cmd_rdy,
   output logic            load,
   output uart_pkg::word_t word
);

   import uart_pkg::*;

   logic  accept;
   byte_t lo_byte;
   byte_t hi_byte;
   word_t word_nxt;

   assign accept  = cmd_vld && cmd_rdy;   // cmd_vld is ignored while busy.
   assign lo_byte = cmd_in[data_w-1:0];
   assign hi_byte = cmd_in[cmd_w-1:data_w];

   // the low byte goes out first, so its frame sits in the lower bits.
   assign word_nxt = {build_frame(hi_byte), build_frame(lo_byte)};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd_rdy <= 1'b1;
         load    <= 1'b0;
      end else begin
         load <= accept;   // one-cycle pulse to the shifter.
         if (accept) begin
            cmd_rdy <= 1'b0;
         end else if (done) begin
            cmd_rdy <= 1'b1;   // the shifter has put out the last bit.
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         word <= word_nxt;
      end
   end

endmodule

// ==== common/uart_pkg.sv ====
package uart_pkg;

   localparam int data_w  = 8;
   localparam int cmd_w   = 16;
   localparam int frame_w = 11;
   localparam int word_w  = 2 * frame_w;   // two frames per command.

   localparam int word_cnt_w  = $clog2(word_w);
   localparam int frame_cnt_w = $clog2(frame_w);

   // positions inside one frame, in the order the bits appear on the line.
   localparam int start_pos = 0;
   localparam int data_lsb  = 1;
   localparam int data_msb  = data_lsb + data_w - 1;
   localparam int par_pos   = data_msb + 1;
   localparam int stop_pos  = par_pos + 1;

   typedef logic [data_w-1:0]  byte_t;
   typedef logic [cmd_w-1:0]   cmd_t;
   typedef logic [frame_w-1:0] frame_t;   // bit 0 is the start bit.
   typedef logic [word_w-1:0]  word_t;    // low-byte frame in the lower half.

   // makes the count of ones over data and parity odd.
   function automatic logic odd_parity(input byte_t data);
      return ~^data;
   endfunction

   function automatic frame_t build_frame(input byte_t data);
      frame_t f;
      f                    = '0;
      f[start_pos]         = 1'b0;
      f[data_msb:data_lsb] = data;
      f[par_pos]           = odd_parity(data);
      f[stop_pos]          = 1'b1;
      return f;
   endfunction

endpackage
